// ==== fpu_cmp_unit.sv ====
// Compare group computing FEQ, FLT, FLE, FMIN and FMAX into one output stage
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [fpu_pkg::FLEN-1:0]  op_a_i,
  input  logic [fpu_pkg::FLEN-1:0]  op_b_i,
  input  fpu_pkg::operation_e       op_i,
  input  fpu_pkg::fp_format_e       fmt_i,
  input  logic [fpu_pkg::TAG_W-1:0] tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic [fpu_pkg::FLEN-1:0]  result_o,
  output fpu_pkg::status_t          status_o,
  output logic [fpu_pkg::TAG_W-1:0] tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);
  import fpu_pkg::*;

  logic [9:0]           cls_a;
  logic [9:0]           cls_b;
  logic                 a_nan;
  logic                 b_nan;
  logic                 any_snan;
  logic                 both_zero;
  logic                 sign_a;
  logic                 sign_b;
  logic [FLEN-2:0]      mag_a;
  logic [FLEN-2:0]      mag_b;
  logic                 eq;
  logic                 lt;
  logic                 min_lt;
  logic [FLEN-1:0]      result;
  status_t              status;
  logic [PAYLOAD_W-1:0] stage_data;

  // ------------------------------------------------------------------------
  // Operand decode
  // ------------------------------------------------------------------------
  assign cls_a     = fp_class(op_a_i, fmt_i);
  assign cls_b     = fp_class(op_b_i, fmt_i);
  assign a_nan     = cls_a[9] | cls_a[8];
  assign b_nan     = cls_b[9] | cls_b[8];
  assign any_snan  = cls_a[8] | cls_b[8];
  assign both_zero = (cls_a[3] | cls_a[4]) & (cls_b[3] | cls_b[4]);

  always_comb begin : split_fields
    if (fmt_i == FP16) begin
      sign_a = op_a_i[15];
      sign_b = op_b_i[15];
      mag_a  = {16'd0, op_a_i[14:0]};
      mag_b  = {16'd0, op_b_i[14:0]};
    end else begin
      sign_a = op_a_i[31];
      sign_b = op_b_i[31];
      mag_a  = op_a_i[30:0];
      mag_b  = op_b_i[30:0];
    end
  end

  // Ordering of non-NaN values, zeros of either sign are equal
  assign eq = both_zero | ((sign_a == sign_b) && (mag_a == mag_b));
  assign lt = ~both_zero & ((sign_a != sign_b) ? sign_a
                                               : (sign_a ? (mag_b < mag_a) : (mag_a < mag_b)));

  // Min/max additionally orders minus zero below plus zero
  assign min_lt = both_zero ? (sign_a & ~sign_b) : lt;

  // ------------------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------------------
  always_comb begin : compute
    result = '0;
    status = '0;
    case (op_i)
      FEQ: begin
        result[0]      = eq & ~a_nan & ~b_nan;
        status[NV_BIT] = any_snan;
      end
      FLT: begin
        result[0]      = lt & ~a_nan & ~b_nan;
        status[NV_BIT] = a_nan | b_nan;
      end
      FLE: begin
        result[0]      = (lt | eq) & ~a_nan & ~b_nan;
        status[NV_BIT] = a_nan | b_nan;
      end
      FMIN, FMAX: begin
        status[NV_BIT] = any_snan;
        if (a_nan && b_nan) begin
          result = (fmt_i == FP16) ? QNAN16 : QNAN32;
        end else if (a_nan) begin
          result = op_b_i;
        end else if (b_nan) begin
          result = op_a_i;
        end else if ((op_i == FMIN) == min_lt) begin
          result = op_a_i;
        end else begin
          result = op_b_i;
        end
        if (fmt_i == FP16) begin
          result[FLEN-1:16] = '1;
        end
      end
      default: ;
    endcase
  end

  fpu_pipe_stage #(
    .payload_t ( logic [PAYLOAD_W-1:0] )
  ) i_out_stage (
    .clk_i       ( clk_i                   ),
    .reset_i     ( reset_i                 ),
    .in_valid_i  ( in_valid_i              ),
    .in_ready_o  ( in_ready_o              ),
    .data_i      ( {result, status, tag_i} ),
    .out_valid_o ( out_valid_o             ),
    .out_ready_i ( out_ready_i             ),
    .data_o      ( stage_data              )
  );

  assign {result_o, status_o, tag_o} = stage_data;
  assign busy_o = out_valid_o;

endmodule

`default_nettype wire

// ==== fpu_dispatch.sv ====
// fpu_lite request dispatcher that steers operations to a group and checks NaN boxing
`timescale 1ns/1ps
`default_nettype none

module fpu_dispatch (
  input  logic [fpu_pkg::FLEN-1:0] operand_a_i,
  input  logic [fpu_pkg::FLEN-1:0] operand_b_i,
  input  fpu_pkg::operation_e      op_i,
  input  fpu_pkg::fp_format_e      fmt_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     cmp_ready_i,
  input  logic                     misc_ready_i,
  input  logic                     cmp_busy_i,
  input  logic                     misc_busy_i,
  output logic                     cmp_valid_o,
  output logic                     misc_valid_o,
  output logic [fpu_pkg::FLEN-1:0] op_a_o,
  output logic [fpu_pkg::FLEN-1:0] op_b_o,
  output logic                     busy_o
);
  import fpu_pkg::*;

  opgroup_e grp;

  // Narrow values must carry all ones above bit 15, anything else reads as NaN
  function automatic logic [FLEN-1:0] unbox(logic [FLEN-1:0] val, fp_format_e fmt);
    if (fmt == FP16 && !(&val[FLEN-1:16])) begin
      return QNAN16;
    end
    return val;
  endfunction

  assign grp = get_opgroup(op_i);

  assign op_a_o = unbox(operand_a_i, fmt_i);
  assign op_b_o = unbox(operand_b_i, fmt_i);

  // ------------------------------------------------------------------------
  // Handshake steering
  // ------------------------------------------------------------------------
  assign cmp_valid_o  = in_valid_i & (grp == GRP_CMP);
  assign misc_valid_o = in_valid_i & (grp == GRP_MISC);

  // Only the addressed group can accept the request
  assign in_ready_o = in_valid_i & ((grp == GRP_CMP) ? cmp_ready_i : misc_ready_i);

  // Something is in flight if either output stage holds an item
  assign busy_o = cmp_busy_i | misc_busy_i;

endmodule

`default_nettype wire

// ==== fpu_lite.f ====
fpu_pkg.sv
fpu_pipe_stage.sv
fpu_dispatch.sv
fpu_cmp_unit.sv
fpu_misc_unit.sv
fpu_rr_arb.sv
fpu_lite_top.sv
fpu_lite_chk.sv
tb_fpu_lite.sv

// ==== fpu_lite_chk.sv ====
// Bound handshake and reset assertions for the fpu_lite top level
`timescale 1ns/1ps
`default_nettype none

module fpu_lite_chk (
  input wire logic                      clk_i,
  input wire logic                      reset_i,
  input wire logic                      in_valid_i,
  input wire logic                      in_ready_o,
  input wire logic [fpu_pkg::FLEN-1:0]  result_o,
  input wire fpu_pkg::status_t          status_o,
  input wire logic [fpu_pkg::TAG_W-1:0] tag_o,
  input wire logic                      out_valid_o,
  input wire logic                      out_ready_i,
  input wire logic                      busy_o
);

  // Set by the first accepted request after reset
  logic seen_input_q;

  // Requests accepted and not yet delivered
  logic [2:0] in_flight_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      seen_input_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      seen_input_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + 3'(in_valid_i && in_ready_o)
                                 - 3'(out_valid_o && out_ready_i);
    end
  end

  quiet_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    !seen_input_q |-> (!out_valid_o && !busy_o))
    else $error("output active before any request was accepted");

  output_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o)))
    else $error("output changed while stalled");

  busy_on_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    (in_valid_i && in_ready_o) |=> busy_o)
    else $error("busy low with a result in flight");

  busy_tracks_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    busy_o == (in_flight_q != 3'd0))
    else $error("busy does not match the results in flight");

endmodule

bind fpu_lite_top fpu_lite_chk i_chk (.*);

`default_nettype wire

// ==== fpu_lite_top.sv ====
// fpu_lite top level joining dispatcher, compare and misc groups and the output arbiter
`timescale 1ns/1ps
`default_nettype none

module fpu_lite_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [fpu_pkg::FLEN-1:0]  operand_a_i,
  input  logic [fpu_pkg::FLEN-1:0]  operand_b_i,
  input  fpu_pkg::operation_e       op_i,
  input  fpu_pkg::fp_format_e       fmt_i,
  input  logic [fpu_pkg::TAG_W-1:0] tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic [fpu_pkg::FLEN-1:0]  result_o,
  output fpu_pkg::status_t          status_o,
  output logic [fpu_pkg::TAG_W-1:0] tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);
  import fpu_pkg::*;

  // Dispatcher to groups
  logic [FLEN-1:0]       op_a;
  logic [FLEN-1:0]       op_b;
  logic                  cmp_valid;
  logic                  cmp_ready;
  logic                  cmp_busy;
  logic                  misc_valid;
  logic                  misc_ready;
  logic                  misc_busy;

  // Groups to arbiter
  logic [NUM_GROUPS-1:0] grp_valid;
  logic [NUM_GROUPS-1:0] grp_ready;
  logic [PAYLOAD_W-1:0]  grp_data [NUM_GROUPS];
  logic [FLEN-1:0]       cmp_result;
  logic [FLEN-1:0]       misc_result;
  status_t               cmp_status;
  status_t               misc_status;
  logic [TAG_W-1:0]      cmp_tag;
  logic [TAG_W-1:0]      misc_tag;

  fpu_dispatch i_dispatch (
    .operand_a_i  ( operand_a_i ),
    .operand_b_i  ( operand_b_i ),
    .op_i         ( op_i        ),
    .fmt_i        ( fmt_i       ),
    .in_valid_i   ( in_valid_i  ),
    .in_ready_o   ( in_ready_o  ),
    .cmp_ready_i  ( cmp_ready   ),
    .misc_ready_i ( misc_ready  ),
    .cmp_busy_i   ( cmp_busy    ),
    .misc_busy_i  ( misc_busy   ),
    .cmp_valid_o  ( cmp_valid   ),
    .misc_valid_o ( misc_valid  ),
    .op_a_o       ( op_a        ),
    .op_b_o       ( op_b        ),
    .busy_o       ( busy_o      )
  );

  // ------------------------------------------------------------------------
  // Operation groups
  // ------------------------------------------------------------------------
  fpu_cmp_unit i_cmp_unit (
    .clk_i       ( clk_i               ),
    .reset_i     ( reset_i             ),
    .op_a_i      ( op_a                ),
    .op_b_i      ( op_b                ),
    .op_i        ( op_i                ),
    .fmt_i       ( fmt_i               ),
    .tag_i       ( tag_i               ),
    .in_valid_i  ( cmp_valid           ),
    .in_ready_o  ( cmp_ready           ),
    .result_o    ( cmp_result          ),
    .status_o    ( cmp_status          ),
    .tag_o       ( cmp_tag             ),
    .out_valid_o ( grp_valid[GRP_CMP]  ),
    .out_ready_i ( grp_ready[GRP_CMP]  ),
    .busy_o      ( cmp_busy            )
  );

  fpu_misc_unit i_misc_unit (
    .clk_i       ( clk_i               ),
    .reset_i     ( reset_i             ),
    .op_a_i      ( op_a                ),
    .op_b_i      ( op_b                ),
    .op_i        ( op_i                ),
    .fmt_i       ( fmt_i               ),
    .tag_i       ( tag_i               ),
    .in_valid_i  ( misc_valid          ),
    .in_ready_o  ( misc_ready          ),
    .result_o    ( misc_result         ),
    .status_o    ( misc_status         ),
    .tag_o       ( misc_tag            ),
    .out_valid_o ( grp_valid[GRP_MISC] ),
    .out_ready_i ( grp_ready[GRP_MISC] ),
    .busy_o      ( misc_busy           )
  );

  assign grp_data[GRP_CMP]  = {cmp_result, cmp_status, cmp_tag};
  assign grp_data[GRP_MISC] = {misc_result, misc_status, misc_tag};

  // ------------------------------------------------------------------------
  // Output merge
  // ------------------------------------------------------------------------
  fpu_rr_arb #(
    .data_t ( logic [PAYLOAD_W-1:0] )
  ) i_arbiter (
    .clk_i   ( clk_i                         ),
    .reset_i ( reset_i                       ),
    .req_i   ( grp_valid                     ),
    .gnt_o   ( grp_ready                     ),
    .data_i  ( grp_data                      ),
    .req_o   ( out_valid_o                   ),
    .gnt_i   ( out_ready_i                   ),
    .data_o  ( {result_o, status_o, tag_o}   )
  );

endmodule

`default_nettype wire

// ==== fpu_misc_unit.sv ====
// Misc group computing sign injection and FCLASS into one output stage
`timescale 1ns/1ps
`default_nettype none

module fpu_misc_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [fpu_pkg::FLEN-1:0]  op_a_i,
  input  logic [fpu_pkg::FLEN-1:0]  op_b_i,
  input  fpu_pkg::operation_e       op_i,
  input  fpu_pkg::fp_format_e       fmt_i,
  input  logic [fpu_pkg::TAG_W-1:0] tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic [fpu_pkg::FLEN-1:0]  result_o,
  output fpu_pkg::status_t          status_o,
  output logic [fpu_pkg::TAG_W-1:0] tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);
  import fpu_pkg::*;

  logic                 sign_a;
  logic                 sign_b;
  logic                 new_sign;
  logic [FLEN-1:0]      result;
  logic [PAYLOAD_W-1:0] stage_data;

  assign sign_a = (fmt_i == FP16) ? op_a_i[15] : op_a_i[31];
  assign sign_b = (fmt_i == FP16) ? op_b_i[15] : op_b_i[31];

  always_comb begin : pick_sign
    case (op_i)
      FSGNJN:  new_sign = ~sign_b;
      FSGNJX:  new_sign = sign_a ^ sign_b;
      default: new_sign = sign_b;
    endcase
  end

  // ------------------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------------------
  always_comb begin : compute
    if (op_i == FCLASS) begin
      result = {{(FLEN-10){1'b0}}, fp_class(op_a_i, fmt_i)};
    end else if (fmt_i == FP16) begin
      // Magnitude of a, boxed in the upper half
      result = {16'hffff, new_sign, op_a_i[14:0]};
    end else begin
      result = {new_sign, op_a_i[30:0]};
    end
  end

  // No operation of this group raises a flag
  fpu_pipe_stage #(
    .payload_t ( logic [PAYLOAD_W-1:0] )
  ) i_out_stage (
    .clk_i       ( clk_i                     ),
    .reset_i     ( reset_i                   ),
    .in_valid_i  ( in_valid_i                ),
    .in_ready_o  ( in_ready_o                ),
    .data_i      ( {result, status_t'(0), tag_i} ),
    .out_valid_o ( out_valid_o               ),
    .out_ready_i ( out_ready_i               ),
    .data_o      ( stage_data                )
  );

  assign {result_o, status_o, tag_o} = stage_data;
  assign busy_o = out_valid_o;

endmodule

`default_nettype wire

// ==== fpu_pipe_stage.sv ====
// Single valid/ready register stage with full throughput over a generic payload
`timescale 1ns/1ps
`default_nettype none

module fpu_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves in this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign data_o      = data_q;

endmodule

`default_nettype wire

// ==== fpu_pkg.sv ====
// fpu_lite shared definitions covering formats, operation codes, flags and decode helpers
`default_nettype none

package fpu_pkg;

  // ------------------------------------------------------------------------
  // Widths and counts
  // ------------------------------------------------------------------------
  localparam int unsigned FLEN       = 32;
  localparam int unsigned TAG_W      = 4;
  localparam int unsigned NUM_GROUPS = 2;

  // Flag vector is ordered NV DZ OF UF NX, MSB first
  localparam int unsigned STATUS_W = 5;
  localparam int unsigned NV_BIT   = 4;

  // Group output payload is result, then status, then tag
  localparam int unsigned PAYLOAD_W = FLEN + STATUS_W + TAG_W;

  // Canonical quiet NaNs, the FP16 one already NaN-boxed
  localparam logic [FLEN-1:0] QNAN32 = 32'h7fc0_0000;
  localparam logic [FLEN-1:0] QNAN16 = 32'hffff_7e00;

  // ------------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [3:0] {
    FEQ, FLT, FLE, FMIN, FMAX,
    FSGNJ, FSGNJN, FSGNJX, FCLASS
  } operation_e;

  typedef enum logic {
    GRP_CMP  = 1'b0,
    GRP_MISC = 1'b1
  } opgroup_e;

  typedef logic [STATUS_W-1:0] status_t;

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic opgroup_e get_opgroup(operation_e op);
    case (op)
      FEQ, FLT, FLE, FMIN, FMAX: return GRP_CMP;
      default:                   return GRP_MISC;
    endcase
  endfunction

  // RISC-V class mask, bit 0 is negative infinity up to bit 9 for quiet NaN
  function automatic logic [9:0] fp_class(logic [FLEN-1:0] val, fp_format_e fmt);
    logic       sign;
    logic       exp_max;
    logic       exp_zero;
    logic       man_zero;
    logic       quiet;
    logic [9:0] cls;
    if (fmt == FP16) begin
      sign     = val[15];
      exp_max  = &val[14:10];
      exp_zero = ~|val[14:10];
      man_zero = ~|val[9:0];
      quiet    = val[9];
    end else begin
      sign     = val[31];
      exp_max  = &val[30:23];
      exp_zero = ~|val[30:23];
      man_zero = ~|val[22:0];
      quiet    = val[22];
    end
    cls = '0;
    if (exp_max && !man_zero) begin
      cls[quiet ? 9 : 8] = 1'b1;
    end else if (exp_max) begin
      cls[sign ? 0 : 7] = 1'b1;
    end else if (exp_zero && man_zero) begin
      cls[sign ? 3 : 4] = 1'b1;
    end else if (exp_zero) begin
      cls[sign ? 2 : 5] = 1'b1;
    end else begin
      cls[sign ? 1 : 6] = 1'b1;
    end
    return cls;
  endfunction

endpackage

`default_nettype wire

// ==== fpu_rr_arb.sv ====
// Two-input round-robin arbiter merging group results onto one valid/ready port
`timescale 1ns/1ps
`default_nettype none

module fpu_rr_arb #(
  parameter type data_t = logic
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [fpu_pkg::NUM_GROUPS-1:0]  req_i,
  output logic [fpu_pkg::NUM_GROUPS-1:0]  gnt_o,
  input  data_t                           data_i [fpu_pkg::NUM_GROUPS],
  output logic                            req_o,
  input  logic                            gnt_i,
  output data_t                           data_o
);
  import fpu_pkg::*;

  // Index of the input with priority, 0 is the compare group
  logic rr_q;
  logic idx;

  // Priority input wins if requesting, otherwise the other one
  assign idx   = req_i[rr_q] ? rr_q : ~rr_q;
  assign req_o = |req_i;

  always_comb begin : grant
    for (int i = 0; i < NUM_GROUPS; i++) begin
      gnt_o[i] = gnt_i & req_i[i] & (idx == i[0]);
    end
  end

  assign data_o = data_i[idx];

  // ------------------------------------------------------------------------
  // Pointer update
  // ------------------------------------------------------------------------
  // A stalled winner keeps priority so the output holds until it transfers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= 1'b0;
    end else if (req_o) begin
      rr_q <= gnt_i ? ~idx : idx;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fpu_lite simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpu_lite -f fpu_lite.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_fpu_lite > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
fi

if grep -q "No errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

// ==== tb_fpu_lite.sv ====
// fpu_lite testbench with LFSR stimulus, reference model and tag scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_lite;
  import fpu_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_RANDOM   = 300;
  localparam int NUM_BURST    = 200;
  localparam int NUM_REQ      = NUM_RANDOM + NUM_BURST;

  logic             clk_i;
  logic             reset_i;
  logic [FLEN-1:0]  operand_a_i;
  logic [FLEN-1:0]  operand_b_i;
  operation_e       op_i;
  fp_format_e       fmt_i;
  logic [TAG_W-1:0] tag_i;
  logic             in_valid_i;
  logic             in_ready_o;
  logic [FLEN-1:0]  result_o;
  status_t          status_o;
  logic [TAG_W-1:0] tag_o;
  logic             out_valid_o;
  logic             out_ready_i;
  logic             busy_o;

  // Scoreboard indexed by tag
  logic [FLEN-1:0]      exp_result [2**TAG_W];
  status_t              exp_status [2**TAG_W];
  logic [2**TAG_W-1:0]  outstanding;
  logic [31:0]          lfsr_state;
  logic                 hold_ready;

  fpu_lite_top i_fpu_lite_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // ------------------------------------------------------------------------
  // Operand generation, biased toward special values
  // ------------------------------------------------------------------------
  function automatic logic [FLEN-1:0] gen_operand(fp_format_e fmt);
    logic [2:0]  kind;
    logic        s;
    logic [31:0] v;
    kind = rand_bits(3);
    s    = rand_bits(1);
    if (fmt == FP16) begin
      case (kind)
        3'd0:    v[15:0] = {s, 15'd0};
        3'd1:    v[15:0] = {s, 5'h1f, 10'd0};
        3'd2:    v[15:0] = {s, 5'h1f, 1'b1, 9'(rand_bits(9))};
        3'd3:    v[15:0] = {s, 5'h1f, 1'b0, 9'(rand_bits(9)) | 9'd1};
        3'd4:    v[15:0] = {s, 5'h00, 10'(rand_bits(10)) | 10'd1};
        default: v[15:0] = 16'(rand_bits(16));
      endcase
      // Occasionally break the NaN box
      v[31:16] = (rand_bits(3) == 3'd0) ? 16'(rand_bits(16)) : 16'hffff;
    end else begin
      case (kind)
        3'd0:    v = {s, 31'd0};
        3'd1:    v = {s, 8'hff, 23'd0};
        3'd2:    v = {s, 8'hff, 1'b1, 22'(rand_bits(22))};
        3'd3:    v = {s, 8'hff, 1'b0, 22'(rand_bits(22)) | 22'd1};
        3'd4:    v = {s, 8'h00, 23'(rand_bits(23)) | 23'd1};
        default: v = rand_bits(32);
      endcase
    end
    return v;
  endfunction

  // Signed ordering key for non-NaN values, both zeros map to 0
  function automatic longint order_key(logic [FLEN-1:0] v, fp_format_e fmt);
    longint mag;
    logic   s;
    mag = (fmt == FP16) ? longint'(v[14:0]) : longint'(v[30:0]);
    s   = (fmt == FP16) ? v[15] : v[31];
    return s ? -mag : mag;
  endfunction

  task automatic ref_model(input logic [FLEN-1:0] a_raw, input logic [FLEN-1:0] b_raw,
                           input operation_e op, input fp_format_e fmt,
                           output logic [FLEN-1:0] res, output status_t st);
    logic [FLEN-1:0] a;
    logic [FLEN-1:0] b;
    logic [9:0]      ca;
    logic [9:0]      cb;
    logic            nan_a;
    logic            nan_b;
    logic            sa;
    logic            sb;
    logic            s;
    logic            pick_a;
    longint          ka;
    longint          kb;
    a = (fmt == FP16 && a_raw[31:16] != 16'hffff) ? 32'hffff_7e00 : a_raw;
    b = (fmt == FP16 && b_raw[31:16] != 16'hffff) ? 32'hffff_7e00 : b_raw;
    ca    = fp_class(a, fmt);
    cb    = fp_class(b, fmt);
    nan_a = ca[9] | ca[8];
    nan_b = cb[9] | cb[8];
    sa    = (fmt == FP16) ? a[15] : a[31];
    sb    = (fmt == FP16) ? b[15] : b[31];
    ka    = order_key(a, fmt);
    kb    = order_key(b, fmt);
    res   = '0;
    st    = '0;
    case (op)
      FEQ: begin
        res[0] = !nan_a && !nan_b && (ka == kb);
        st[4]  = ca[8] | cb[8];
      end
      FLT: begin
        res[0] = !nan_a && !nan_b && (ka < kb);
        st[4]  = nan_a | nan_b;
      end
      FLE: begin
        res[0] = !nan_a && !nan_b && (ka <= kb);
        st[4]  = nan_a | nan_b;
      end
      FMIN, FMAX: begin
        st[4] = ca[8] | cb[8];
        if (op == FMIN) begin
          pick_a = (ka < kb) || (ka == kb && sa);
        end else begin
          pick_a = (ka > kb) || (ka == kb && !sa);
        end
        if (nan_a && nan_b) begin
          res = (fmt == FP16) ? 32'hffff_7e00 : 32'h7fc0_0000;
        end else if (nan_a) begin
          res = b;
        end else if (nan_b || pick_a) begin
          res = a;
        end else begin
          res = b;
        end
        if (fmt == FP16) begin
          res[31:16] = 16'hffff;
        end
      end
      FCLASS: res = {22'd0, ca};
      default: begin
        s = (op == FSGNJ) ? sb : ((op == FSGNJN) ? ~sb : sa ^ sb);
        res = (fmt == FP16) ? {16'hffff, s, a[14:0]} : {s, a[30:0]};
      end
    endcase
  endtask

  // ------------------------------------------------------------------------
  // Request driver
  // ------------------------------------------------------------------------
  task automatic send_request(input logic [TAG_W-1:0] tag);
    operation_e      op;
    fp_format_e      fmt;
    logic [FLEN-1:0] a;
    logic [FLEN-1:0] b;
    logic [FLEN-1:0] res;
    status_t         st;
    op  = operation_e'(rand_bits(4) % 9);
    fmt = fp_format_e'(rand_bits(1));
    a   = gen_operand(fmt);
    b   = gen_operand(fmt);
    ref_model(a, b, op, fmt, res, st);
    // Never reuse a tag that is still in flight
    while (outstanding[tag]) begin
      @(posedge clk_i);
      #1;
    end
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    fmt_i       = fmt;
    tag_i       = tag;
    in_valid_i  = 1'b1;
    forever begin
      @(negedge clk_i);
      if (in_ready_o) break;
    end
    exp_result[tag]  = res;
    exp_status[tag]  = st;
    outstanding[tag] = 1'b1;
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  // Output sink with random back-pressure
  initial begin
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      out_ready_i = hold_ready | (rand_bits(2) != 2'd0);
    end
  end

  // Checks the item that transfers on the coming rising edge
  always @(negedge clk_i) begin
    if (!reset_i && out_valid_o && out_ready_i) begin
      assert (outstanding[tag_o])
      else stop_with_failure($sformatf("Result with tag %0d arrived but was not expected",
                                       tag_o));
      assert (result_o == exp_result[tag_o])
      else stop_with_failure($sformatf("ERROR %0t result_o expected %h actual %h",
                                       $time, exp_result[tag_o], result_o));
      assert (status_o == exp_status[tag_o])
      else stop_with_failure($sformatf("ERROR %0t status_o expected %b actual %b",
                                       $time, exp_status[tag_o], status_o));
      outstanding[tag_o] = 1'b0;
    end
  end

  initial begin
    #((NUM_REQ * 20 + RESET_CYCLES + 20) * 10);
    stop_with_failure("Timeout, the run did not finish in time");
  end

  initial begin
    int unsigned tag_ctr;
    lfsr_state  = 32'h87a1;
    outstanding = '0;
    hold_ready  = 1'b0;
    reset_i     = 1'b1;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = FEQ;
    fmt_i       = FP32;
    tag_i       = '0;
    tag_ctr     = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;

    // Random traffic with idle gaps and back-pressure
    for (int i = 0; i < NUM_RANDOM; i++) begin
      send_request(tag_ctr[TAG_W-1:0]);
      tag_ctr++;
      if (rand_bits(2) == 2'd0) begin
        @(posedge clk_i);
        #1;
      end
    end

    // Back-to-back traffic with the output always ready
    hold_ready = 1'b1;
    for (int i = 0; i < NUM_BURST; i++) begin
      send_request(tag_ctr[TAG_W-1:0]);
      tag_ctr++;
    end

    repeat (20) @(posedge clk_i);
    if (|outstanding) begin
      stop_with_failure($sformatf("Results never returned for tags %b", outstanding));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
